// File: l2_pkg.sv
package l2_pkg;

        // cache geometry
        localparam int ADDR_W = 32;
        localparam int WAYS   = 4;
        localparam int WAY_W  = 2;
        localparam int SETS   = 64;
        localparam int SET_W  = 6;
        localparam int OFS_W  = 5;                       // 32-byte lines
        localparam int LINE_W = 256;
        localparam int TAG_W  = ADDR_W - SET_W - OFS_W;  // 21 bits

        // aging replacement
        localparam int AGE_W   = 3;
        localparam int AGE_TOP = 4;                      // value loaded on access

        typedef logic [ADDR_W-1:0] addr_t;
        typedef logic [LINE_W-1:0] line_t;
        typedef logic [TAG_W-1:0]  tag_t;
        typedef logic [SET_W-1:0]  set_t;
        typedef logic [WAY_W-1:0]  way_t;
        typedef logic [WAYS-1:0]   way_mask_t;
        typedef logic [AGE_W-1:0]  age_t;

        typedef enum logic [2:0] {
                IDLE,
                LOOKUP,     // two cycles, compare then decide
                FILL_REQ,
                FILL_DONE,
                WR_REQ,
                WR_DONE,
                RESP
        } ctrl_state_t;

endpackage

// File: l2_tag_array.sv
module l2_tag_array (
        input  logic              clk,
        input  logic              rst_n,
        input  l2_pkg::set_t      lookup_set,
        input  l2_pkg::tag_t      lookup_tag,
        input  logic              fill_en,
        input  l2_pkg::way_t      fill_way,
        output l2_pkg::way_mask_t hit_mask,
        output l2_pkg::way_mask_t valid_mask
);
        import l2_pkg::*;

        tag_t      tag_q   [SETS][WAYS];
        way_mask_t valid_q [SETS];

        // valid bits, cleared on reset
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int s = 0; s < SETS; s++) begin
                                valid_q[s] <= '0;
                        end
                end else if (fill_en) begin
                        valid_q[lookup_set][fill_way] <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (fill_en) begin
                        tag_q[lookup_set][fill_way] <= lookup_tag;  // tag of the line being filled
                end
        end

        assign valid_mask = valid_q[lookup_set];

        // all ways compared at once
        always_comb begin
                for (int w = 0; w < WAYS; w++) begin
                        hit_mask[w] = valid_mask[w] && (tag_q[lookup_set][w] == lookup_tag);
                end
        end

endmodule

// File: l2_data_array.sv
module l2_data_array (
        input  logic          clk,
        input  l2_pkg::set_t  data_set,
        input  l2_pkg::way_t  data_way,
        input  logic          data_we,
        input  l2_pkg::line_t data_wline,
        output l2_pkg::line_t data_rline
);
        import l2_pkg::*;

        line_t mem [SETS][WAYS];

        // refills and write hits share this port
        always_ff @(posedge clk) begin
                if (data_we) begin
                        mem[data_set][data_way] <= data_wline;
                end
        end

        assign data_rline = mem[data_set][data_way];  // async read

endmodule

// File: l2_replace.sv
module l2_replace (
        input  logic              clk,
        input  logic              rst_n,
        input  l2_pkg::set_t      age_set,
        input  l2_pkg::way_mask_t valid_mask,
        input  logic              touch_en,
        input  l2_pkg::way_t      touch_way,
        output l2_pkg::way_t      victim
);
        import l2_pkg::*;

        age_t age_q [SETS][WAYS];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int s = 0; s < SETS; s++) begin
                                for (int w = 0; w < WAYS; w++) begin
                                        age_q[s][w] <= '0;
                                end
                        end
                end else if (touch_en) begin
                        for (int w = 0; w < WAYS; w++) begin
                                if (way_t'(w) == touch_way) begin
                                        age_q[age_set][w] <= age_t'(AGE_TOP);
                                end else if (age_q[age_set][w] != '0) begin
                                        age_q[age_set][w] <= age_q[age_set][w] - 1'b1;  // others age
                                end
                        end
                end
        end

        // invalid way first, else youngest count loses, lowest index on ties
        always_comb begin
                logic found;
                age_t best_age;
                victim   = '0;
                found    = 1'b0;
                best_age = age_q[age_set][0];
                for (int w = 0; w < WAYS; w++) begin
                        if (!found && !valid_mask[w]) begin
                                victim = way_t'(w);
                                found  = 1'b1;
                        end
                end
                if (!found) begin
                        for (int w = 1; w < WAYS; w++) begin
                                if (age_q[age_set][w] < best_age) begin
                                        best_age = age_q[age_set][w];
                                        victim   = way_t'(w);
                                end
                        end
                end
        end

endmodule

// File: l2_ctrl.sv
module l2_ctrl (
        input  logic              clk,
        input  logic              rst_n,
        // data read port
        input  logic              d_rd_req,
        input  l2_pkg::addr_t     d_rd_addr,
        output logic              d_rd_ack,
        output logic              d_rd_hit,
        output l2_pkg::line_t     d_rd_data,
        // instruction read port
        input  logic              i_rd_req,
        input  l2_pkg::addr_t     i_rd_addr,
        output logic              i_rd_ack,
        output logic              i_rd_hit,
        output l2_pkg::line_t     i_rd_data,
        // data write port
        input  logic              d_wr_req,
        input  l2_pkg::addr_t     d_wr_addr,
        input  l2_pkg::line_t     d_wr_data,
        output logic              d_wr_ack,
        output logic              d_wr_hit,
        // L3 read and write
        output logic              l3_rd_req,
        output l2_pkg::addr_t     l3_rd_addr,
        input  logic              l3_rd_ack,
        input  l2_pkg::line_t     l3_rd_data,
        output logic              l3_wr_req,
        output l2_pkg::addr_t     l3_wr_addr,
        output l2_pkg::line_t     l3_wr_data,
        input  logic              l3_wr_ack,
        // arrays
        output l2_pkg::set_t      lookup_set,
        output l2_pkg::tag_t      lookup_tag,
        output logic              fill_en,
        output l2_pkg::way_t      fill_way,
        input  l2_pkg::way_mask_t hit_mask,
        output l2_pkg::set_t      data_set,
        output l2_pkg::way_t      data_way,
        output logic              data_we,
        output l2_pkg::line_t     data_wline,
        input  l2_pkg::line_t     data_rline,
        output logic              touch_en,
        output l2_pkg::way_t      touch_way,
        input  l2_pkg::way_t      victim
);
        import l2_pkg::*;

        ctrl_state_t state;
        logic        sel_dw, sel_dr, sel_ir;  // port in service
        logic        lk_done;                 // second lookup cycle
        logic        hit_r;
        way_t        way_r, victim_r, hit_way;
        addr_t       req_addr, line_addr;
        line_t       wr_line, rline_r;
        logic        pick_dw, pick_dr, pick_ir;
        logic        port_req, decide, fill;

        // fixed priority: write, data read, instruction read
        assign pick_dw  = d_wr_req;
        assign pick_dr  = !d_wr_req && d_rd_req;
        assign pick_ir  = !d_wr_req && !d_rd_req && i_rd_req;
        assign port_req = sel_dw ? d_wr_req : (sel_dr ? d_rd_req : i_rd_req);

        assign decide = (state == LOOKUP) && lk_done;
        assign fill   = (state == FILL_REQ) && l3_rd_ack;

        assign lookup_set = req_addr[OFS_W +: SET_W];
        assign lookup_tag = req_addr[ADDR_W-1 -: TAG_W];
        assign line_addr  = {req_addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

        assign fill_en    = fill;
        assign fill_way   = victim_r;
        assign data_set   = lookup_set;
        assign data_way   = (state == FILL_REQ) ? victim_r : way_r;
        assign data_we    = fill || (decide && sel_dw && hit_r);  // refill or write hit
        assign data_wline = (state == FILL_REQ) ? l3_rd_data : wr_line;
        assign touch_en   = fill || (decide && hit_r);
        assign touch_way  = data_way;

        assign l3_rd_addr = line_addr;
        assign l3_wr_addr = line_addr;
        assign l3_wr_data = wr_line;
        assign d_rd_data  = rline_r;
        assign i_rd_data  = rline_r;

        always_comb begin
                hit_way = '0;
                for (int w = 0; w < WAYS; w++) begin
                        if (hit_mask[w]) begin
                                hit_way = way_t'(w);
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state     <= IDLE;
                        sel_dw    <= 1'b0;
                        sel_dr    <= 1'b0;
                        sel_ir    <= 1'b0;
                        lk_done   <= 1'b0;
                        hit_r     <= 1'b0;
                        d_rd_ack  <= 1'b0;
                        d_rd_hit  <= 1'b0;
                        i_rd_ack  <= 1'b0;
                        i_rd_hit  <= 1'b0;
                        d_wr_ack  <= 1'b0;
                        d_wr_hit  <= 1'b0;
                        l3_rd_req <= 1'b0;
                        l3_wr_req <= 1'b0;
                end else begin
                        case (state)
                        IDLE: begin
                                if (pick_dw || pick_dr || pick_ir) begin
                                        sel_dw <= pick_dw;
                                        sel_dr <= pick_dr;
                                        sel_ir <= pick_ir;
                                        state  <= LOOKUP;
                                end
                        end
                        LOOKUP: begin
                                if (!lk_done) begin
                                        lk_done <= 1'b1;
                                        hit_r   <= |hit_mask;
                                end else begin
                                        lk_done <= 1'b0;
                                        if (sel_dw) begin
                                                l3_wr_req <= 1'b1;  // write-through, hit or not
                                                state     <= WR_REQ;
                                        end else if (hit_r) begin
                                                d_rd_ack <= sel_dr;
                                                d_rd_hit <= sel_dr;
                                                i_rd_ack <= sel_ir;
                                                i_rd_hit <= sel_ir;
                                                state    <= RESP;
                                        end else begin
                                                l3_rd_req <= 1'b1;
                                                state     <= FILL_REQ;
                                        end
                                end
                        end
                        FILL_REQ: begin
                                if (l3_rd_ack) begin
                                        l3_rd_req <= 1'b0;
                                        state     <= FILL_DONE;
                                end
                        end
                        FILL_DONE: begin
                                if (!l3_rd_ack) begin
                                        d_rd_ack <= sel_dr;  // hit stays low
                                        i_rd_ack <= sel_ir;
                                        state    <= RESP;
                                end
                        end
                        WR_REQ: begin
                                if (l3_wr_ack) begin
                                        l3_wr_req <= 1'b0;
                                        state     <= WR_DONE;
                                end
                        end
                        WR_DONE: begin
                                if (!l3_wr_ack) begin
                                        d_wr_ack <= 1'b1;
                                        d_wr_hit <= hit_r;
                                        state    <= RESP;
                                end
                        end
                        RESP: begin
                                if (!port_req) begin
                                        d_rd_ack <= 1'b0;
                                        d_rd_hit <= 1'b0;
                                        i_rd_ack <= 1'b0;
                                        i_rd_hit <= 1'b0;
                                        d_wr_ack <= 1'b0;
                                        d_wr_hit <= 1'b0;
                                        sel_dw   <= 1'b0;
                                        sel_dr   <= 1'b0;
                                        sel_ir   <= 1'b0;
                                        state    <= IDLE;
                                end
                        end
                        default: state <= IDLE;
                        endcase
                end
        end

        // request address, write data and result line
        always_ff @(posedge clk) begin
                if (state == IDLE) begin
                        if (pick_dw) begin
                                req_addr <= d_wr_addr;
                                wr_line  <= d_wr_data;
                        end else if (pick_dr) begin
                                req_addr <= d_rd_addr;
                        end else if (pick_ir) begin
                                req_addr <= i_rd_addr;
                        end
                end
                if ((state == LOOKUP) && !lk_done) begin
                        way_r    <= hit_way;
                        victim_r <= victim;  // held through the refill
                end
                if (decide && hit_r && !sel_dw) begin
                        rline_r <= data_rline;
                end
                if (fill) begin
                        rline_r <= l3_rd_data;
                end
        end

endmodule

// File: l2_cache.sv
module l2_cache (
        input  logic          clk,
        input  logic          rst_n,
        input  logic          d_rd_req,
        input  l2_pkg::addr_t d_rd_addr,
        output logic          d_rd_ack,
        output logic          d_rd_hit,
        output l2_pkg::line_t d_rd_data,
        input  logic          i_rd_req,
        input  l2_pkg::addr_t i_rd_addr,
        output logic          i_rd_ack,
        output logic          i_rd_hit,
        output l2_pkg::line_t i_rd_data,
        input  logic          d_wr_req,
        input  l2_pkg::addr_t d_wr_addr,
        input  l2_pkg::line_t d_wr_data,
        output logic          d_wr_ack,
        output logic          d_wr_hit,
        output logic          l3_rd_req,
        output l2_pkg::addr_t l3_rd_addr,
        input  logic          l3_rd_ack,
        input  l2_pkg::line_t l3_rd_data,
        output logic          l3_wr_req,
        output l2_pkg::addr_t l3_wr_addr,
        output l2_pkg::line_t l3_wr_data,
        input  logic          l3_wr_ack
);
        import l2_pkg::*;

        set_t      lookup_set, data_set;
        tag_t      lookup_tag;
        logic      fill_en, data_we, touch_en;
        way_t      fill_way, data_way, touch_way, victim;
        way_mask_t hit_mask, valid_mask;
        line_t     data_wline, data_rline;

        l2_ctrl u_ctrl (.*);

        l2_tag_array u_tags (
                .clk        (clk),
                .rst_n      (rst_n),
                .lookup_set (lookup_set),
                .lookup_tag (lookup_tag),
                .fill_en    (fill_en),
                .fill_way   (fill_way),
                .hit_mask   (hit_mask),
                .valid_mask (valid_mask)
        );

        l2_data_array u_data (
                .clk        (clk),
                .data_set   (data_set),
                .data_way   (data_way),
                .data_we    (data_we),
                .data_wline (data_wline),
                .data_rline (data_rline)
        );

        l2_replace u_replace (
                .clk        (clk),
                .rst_n      (rst_n),
                .age_set    (lookup_set),  // ages follow the looked-up set
                .valid_mask (valid_mask),
                .touch_en   (touch_en),
                .touch_way  (touch_way),
                .victim     (victim)
        );

endmodule

// File: l2_cache_tb.sv
module l2_cache_tb;
        import l2_pkg::*;

        localparam int RESET_CYCLES      = 4;
        localparam int CYCLES_PER_VECTOR = 40;

        logic  clk;
        logic  rst_n;
        logic  d_rd_req, i_rd_req, d_wr_req;
        addr_t d_rd_addr, i_rd_addr, d_wr_addr;
        line_t d_wr_data;
        logic  d_rd_ack, d_rd_hit, i_rd_ack, i_rd_hit, d_wr_ack, d_wr_hit;
        line_t d_rd_data, i_rd_data;
        logic  l3_rd_req, l3_rd_ack, l3_wr_req, l3_wr_ack;
        addr_t l3_rd_addr, l3_wr_addr;
        line_t l3_rd_data, l3_wr_data;

        // vector columns loaded before reset ends
        string       port_q[$];
        addr_t       addr_q[$];
        logic [31:0] wdata_q[$];
        logic        hit_q[$];
        logic [31:0] word_q[$];
        logic        loaded;

        line_t l3_mem [addr_t];  // lines written through to L3

        // what the L3 side should see for the request in flight
        addr_t req_line_addr;
        line_t req_wr_line;

        l2_cache u_l2_cache (.*);

        always #50 clk = ~clk;

        // inputs change 5 units after the rising edge
        task automatic wait_drive_slot();
                @(posedge clk);
                #5;
        endtask

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("=== FAIL ===");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_line(input string name, input line_t expected, input line_t actual);
                if (actual !== expected) begin
                        $display("FAIL t=%0t %s expected %h actual %h",
                                 $time, name, expected, actual);
                        abort_run("line value differs from the expected line");
                end
        endtask

        task automatic check_hit(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("FAIL t=%0t %s expected %b actual %b",
                                 $time, name, expected, actual);
                        abort_run("hit flag differs from the expected flag");
                end
        endtask

        task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
                if (actual !== expected) begin
                        $display("FAIL t=%0t %s expected %h actual %h",
                                 $time, name, expected, actual);
                        abort_run("L3 address differs from the expected line address");
                end
        endtask

        // unwritten lines hold 8 copies of their own address
        function automatic line_t l3_line(input addr_t a);
                if (l3_mem.exists(a)) begin
                        return l3_mem[a];
                end
                return {8{a}};
        endfunction

        function automatic logic port_ack(input string port);
                case (port)
                "DW": return d_wr_ack;
                "DR": return d_rd_ack;
                default: return i_rd_ack;
                endcase
        endfunction

        task automatic run_request(input string port, input addr_t addr, input line_t wdata,
                                   input logic exp_hit, input line_t exp_line);
                req_line_addr = addr & ~addr_t'(LINE_W / 8 - 1);  // byte offset dropped
                req_wr_line   = wdata;
                case (port)
                "DW": begin
                        d_wr_addr = addr;
                        d_wr_data = wdata;
                        d_wr_req  = 1'b1;
                end
                "DR": begin
                        d_rd_addr = addr;
                        d_rd_req  = 1'b1;
                end
                default: begin
                        i_rd_addr = addr;
                        i_rd_req  = 1'b1;
                end
                endcase
                do begin
                        wait_drive_slot();
                end while (!port_ack(port));
                case (port)
                "DW": check_hit("d_wr_hit", exp_hit, d_wr_hit);
                "DR": begin
                        check_hit("d_rd_hit", exp_hit, d_rd_hit);
                        check_line("d_rd_data", exp_line, d_rd_data);
                end
                default: begin
                        check_hit("i_rd_hit", exp_hit, i_rd_hit);
                        check_line("i_rd_data", exp_line, i_rd_data);
                end
                endcase
                d_wr_req = 1'b0;
                d_rd_req = 1'b0;
                i_rd_req = 1'b0;
                do begin
                        wait_drive_slot();
                end while (port_ack(port));  // release phase
        endtask

        // L3 answers one request at a time after 1 to 4 cycles
        initial begin : l3_model
                int delay;
                l3_rd_ack  = 1'b0;
                l3_wr_ack  = 1'b0;
                l3_rd_data = '0;
                void'($urandom(59581));
                forever begin
                        wait_drive_slot();
                        if (l3_rd_req || l3_wr_req) begin
                                delay = $urandom_range(4, 1);
                                repeat (delay) wait_drive_slot();
                                if (l3_rd_req) begin
                                        check_addr("l3_rd_addr", req_line_addr, l3_rd_addr);
                                        l3_rd_data = l3_line(l3_rd_addr);
                                        l3_rd_ack  = 1'b1;
                                end else begin
                                        check_addr("l3_wr_addr", req_line_addr, l3_wr_addr);
                                        check_line("l3_wr_data", req_wr_line, l3_wr_data);
                                        l3_mem[l3_wr_addr] = l3_wr_data;
                                        l3_wr_ack          = 1'b1;
                                end
                                while (l3_rd_req || l3_wr_req) wait_drive_slot();
                                l3_rd_ack = 1'b0;
                                l3_wr_ack = 1'b0;
                        end
                end
        end

        initial begin : watchdog
                int limit;
                wait (loaded);
                limit = addr_q.size() * CYCLES_PER_VECTOR + RESET_CYCLES;
                repeat (limit) @(posedge clk);
                abort_run("timeout, the DUT stopped responding to requests");
        end

        initial begin : main
                int          fd;
                int          code;
                int          hit;
                string       tok;
                string       rest;
                logic [31:0] a, w, e;
                clk           = 1'b0;
                rst_n         = 1'b0;
                loaded        = 1'b0;
                d_rd_req      = 1'b0;
                i_rd_req      = 1'b0;
                d_wr_req      = 1'b0;
                d_rd_addr     = '0;
                i_rd_addr     = '0;
                d_wr_addr     = '0;
                d_wr_data     = '0;
                req_line_addr = '0;
                req_wr_line   = '0;
                fd = $fopen("l2_vectors.txt", "r");
                if (fd == 0) begin
                        abort_run("cannot open l2_vectors.txt");
                end
                while (!$feof(fd)) begin
                        code = $fscanf(fd, "%s", tok);
                        if (code != 1) begin
                                break;
                        end
                        if (tok[0] == "#") begin
                                code = $fgets(rest, fd);  // skip comment line
                        end else begin
                                code = $fscanf(fd, "%h %h %d %h", a, w, hit, e);
                                if (code != 4 || (tok != "DR" && tok != "IR" && tok != "DW")) begin
                                        abort_run("malformed line in l2_vectors.txt");
                                end
                                port_q.push_back(tok);
                                addr_q.push_back(a);
                                wdata_q.push_back(w);
                                hit_q.push_back(hit != 0);
                                word_q.push_back(e);
                        end
                end
                $fclose(fd);
                loaded = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                #5;
                rst_n = 1'b1;
                foreach (port_q[i]) begin
                        run_request(port_q[i], addr_q[i], {8{wdata_q[i]}},
                                    hit_q[i], {8{word_q[i]}});
                end
                $display("=== PASS ===");
                $finish;
        end

endmodule

// File: l2_vectors.txt
# port addr wdata_word exp_hit exp_word
# lines are 8 copies of the word, port is DR, IR or DW
DR 00010040 00000000 0 00010040
DR 00010044 00000000 1 00010040
IR 00010040 00000000 1 00010040
IR 00200060 00000000 0 00200060
IR 00200060 00000000 1 00200060
DR 00200060 00000000 1 00200060
DW 00300080 aaaa0001 0 00000000
DR 00300080 00000000 0 aaaa0001
DR 00300080 00000000 1 aaaa0001
DW 00010040 5555beef 1 00000000
DR 00010040 00000000 1 5555beef
IR 00010040 00000000 1 5555beef
DR 004000a0 00000000 0 004000a0
DR 004008a0 00000000 0 004008a0
DR 004010a0 00000000 0 004010a0
DR 004018a0 00000000 0 004018a0
DR 004000a0 00000000 1 004000a0
DR 004020a0 00000000 0 004020a0
DR 004000a0 00000000 1 004000a0
DR 004008a0 00000000 0 004008a0
DR 004018a0 00000000 1 004018a0
DR 004020a0 00000000 1 004020a0
DR 004010a0 00000000 0 004010a0
DW 00500020 12345678 0 00000000
IR 00500020 00000000 0 12345678
DR 00500020 00000000 1 12345678
DW 00500020 87654321 1 00000000
IR 00500020 00000000 1 87654321
DR 00600020 00000000 0 00600020

// File: src.f
l2_pkg.sv
l2_tag_array.sv
l2_data_array.sv
l2_replace.sv
l2_ctrl.sv
l2_cache.sv
l2_cache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = l2_cache_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
